/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

PASS_MSG  := All tests passed
SOURCES   := $(shell grep -v '^+' $(FILELIST)) tests/tb_checks.svh
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+tests
source/mem_pkg.sv
source/mem_arb.sv
source/burst_seq.sv
source/mem_array.sv
source/mem_subsys.sv
tests/tb_mem_subsys.sv

/* source/burst_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_seq import mem_pkg::*; #(
  parameter int addr_width     = 10,
  parameter int burstlen_width = 3
) (
  input  logic                      clock,
  input  logic                      rst_n,

  input  logic                      req_rd,
  input  logic                      req_wr,
  input  logic [addr_width-1:0]     req_addr,
  input  logic [burstlen_width-1:0] req_burst_len,
  input  word_t                     req_wr_data,
  input  be_t                       req_wr_be,
  input  client_t                   req_client,

  input  word_t                     mem_rd_data,

  output logic                      busy,
  output logic                      beat_valid,
  output client_t                   beat_client,
  output word_t                     beat_data,

  output logic [addr_width-1:0]     mem_addr,
  output logic                      mem_wr,
  output word_t                     mem_wr_data,
  output be_t                       mem_wr_be
);

  logic                      active;   // Issuing beat addresses
  logic [addr_width-1:0]     addr_r;
  logic [burstlen_width-1:0] beats_left;
  client_t                   client_r;

  // Burst control
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      active     <= 1'b0;
      beats_left <= '0;
    end else if (req_rd) begin
      active     <= 1'b1;
      beats_left <= req_burst_len;
    end else if (active) begin
      if (beats_left == '0) begin
        active <= 1'b0;
      end else begin
        beats_left <= beats_left - 1'b1;
      end
    end
  end

  // Address walk wraps at the top of memory
  always_ff @(posedge clock) begin
    if (req_rd) begin
      addr_r   <= req_addr;
      client_r <= req_client;
    end else if (active) begin
      addr_r <= addr_r + 1'b1;
    end
  end

  // Array read takes one cycle, so the tag trails the address
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= active;
    end
  end

  // Owner is stable until busy drops
  assign beat_client = client_r;
  assign beat_data   = mem_rd_data;

  assign busy = active | beat_valid;

  // Writes go through in the accepting cycle
  assign mem_addr    = active ? addr_r : req_addr;
  assign mem_wr      = req_wr;
  assign mem_wr_data = req_wr_data;
  assign mem_wr_be   = req_wr_be;

endmodule

`default_nettype wire

/* source/mem_arb.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arb import mem_pkg::*; #(
  parameter int addr_width     = 10,
  parameter int burstlen_width = 3
) (
  input  logic                      clock,
  input  logic                      rst_n,

  input  logic [addr_width-1:0]     c1_addr,
  input  logic [burstlen_width-1:0] c1_burst_len,
  input  logic                      c1_rd,
  output word_t                     c1_rd_data,
  output logic                      c1_rd_valid,
  output logic                      c1_waitrequest,

  input  logic [addr_width-1:0]     c2_addr,
  input  logic [burstlen_width-1:0] c2_burst_len,
  input  logic                      c2_rd,
  input  logic                      c2_wr,
  input  word_t                     c2_wr_data,
  input  be_t                       c2_wr_be,
  output word_t                     c2_rd_data,
  output logic                      c2_rd_valid,
  output logic                      c2_waitrequest,

  input  logic                      busy,
  input  logic                      beat_valid,
  input  client_t                   beat_client,
  input  word_t                     beat_data,

  output logic                      req_rd,
  output logic                      req_wr,
  output logic [addr_width-1:0]     req_addr,
  output logic [burstlen_width-1:0] req_burst_len,
  output word_t                     req_wr_data,
  output be_t                       req_wr_be,
  output client_t                   req_client
);

  logic    c1_req;
  logic    c2_req;
  client_t grant;
  client_t last_client;
  logic    take;

  assign c1_req = c1_rd;
  assign c2_req = c2_rd | c2_wr;

  // Round robin gives a tie to the port not served last
  always_comb begin
    if (c1_req && c2_req) begin
      grant = (last_client == client_instr) ? client_data : client_instr;
    end else if (c2_req) begin
      grant = client_data;
    end else begin
      grant = client_instr;
    end
  end

  assign take = !busy && ((grant == client_instr) ? c1_req : c2_req);

  assign c1_waitrequest = !(take && grant == client_instr);
  assign c2_waitrequest = !(take && grant == client_data);

  // Accepted request is valid for the accepting cycle only
  assign req_rd        = take && ((grant == client_instr) ? c1_rd : c2_rd);
  assign req_wr        = take && grant == client_data && c2_wr; // c1 never writes
  assign req_addr      = (grant == client_instr) ? c1_addr : c2_addr;
  assign req_burst_len = (grant == client_instr) ? c1_burst_len : c2_burst_len;
  assign req_wr_data   = c2_wr_data;
  assign req_wr_be     = c2_wr_be;
  assign req_client    = grant;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      last_client <= client_data; // c1 wins the first tie
    end else if (take) begin
      last_client <= grant;
    end
  end

  // Beat return is steered by the owner tag
  assign c1_rd_valid = beat_valid && beat_client == client_instr;
  assign c2_rd_valid = beat_valid && beat_client == client_data;
  assign c1_rd_data  = beat_data;
  assign c2_rd_data  = beat_data;

endmodule

`default_nettype wire

/* source/mem_array.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_array import mem_pkg::*; #(
  parameter int addr_width = 10
) (
  input  logic                  clock,
  input  logic [addr_width-1:0] mem_addr,
  input  logic                  mem_wr,
  input  word_t                 mem_wr_data,
  input  be_t                   mem_wr_be,
  output word_t                 mem_rd_data
);

  localparam int depth = 2 ** addr_width;

  word_t mem [depth];

  // Byte lane writes
  always_ff @(posedge clock) begin
    if (mem_wr) begin
      for (int b = 0; b < word_bytes; b++) begin
        if (mem_wr_be[b]) begin
          mem[mem_addr][8*b +: 8] <= mem_wr_data[8*b +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clock) begin
    mem_rd_data <= mem[mem_addr];
  end

endmodule

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  localparam int word_width = 32;
  localparam int word_bytes = word_width / 8;

  // Accepting edge to first valid beat
  localparam int read_latency = 2;

  typedef logic [word_width-1:0] word_t;
  typedef logic [word_bytes-1:0] be_t;

  typedef enum logic {
    client_instr = 1'b0, // Port c1
    client_data  = 1'b1  // Port c2
  } client_t;

endpackage

`default_nettype wire

/* source/mem_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsys import mem_pkg::*; #(
  parameter int addr_width     = 10,
  parameter int burstlen_width = 3
) (
  input  logic                      clock,
  input  logic                      rst_n,

  input  logic [addr_width-1:0]     c1_addr,
  input  logic [burstlen_width-1:0] c1_burst_len,
  input  logic                      c1_rd,
  output word_t                     c1_rd_data,
  output logic                      c1_rd_valid,
  output logic                      c1_waitrequest,

  input  logic [addr_width-1:0]     c2_addr,
  input  logic [burstlen_width-1:0] c2_burst_len,
  input  logic                      c2_rd,
  input  logic                      c2_wr,
  input  word_t                     c2_wr_data,
  input  be_t                       c2_wr_be,
  output word_t                     c2_rd_data,
  output logic                      c2_rd_valid,
  output logic                      c2_waitrequest
);

  logic                      req_rd;
  logic                      req_wr;
  logic [addr_width-1:0]     req_addr;
  logic [burstlen_width-1:0] req_burst_len;
  word_t                     req_wr_data;
  be_t                       req_wr_be;
  client_t                   req_client;

  logic                      busy;
  logic                      beat_valid;
  client_t                   beat_client;
  word_t                     beat_data;

  logic [addr_width-1:0]     mem_addr;
  logic                      mem_wr;
  word_t                     mem_wr_data;
  be_t                       mem_wr_be;
  word_t                     mem_rd_data;

  mem_arb #(
    .addr_width     (addr_width),
    .burstlen_width (burstlen_width)
  ) arb0 (
    .clock          (clock),
    .rst_n          (rst_n),
    .c1_addr        (c1_addr),
    .c1_burst_len   (c1_burst_len),
    .c1_rd          (c1_rd),
    .c1_rd_data     (c1_rd_data),
    .c1_rd_valid    (c1_rd_valid),
    .c1_waitrequest (c1_waitrequest),
    .c2_addr        (c2_addr),
    .c2_burst_len   (c2_burst_len),
    .c2_rd          (c2_rd),
    .c2_wr          (c2_wr),
    .c2_wr_data     (c2_wr_data),
    .c2_wr_be       (c2_wr_be),
    .c2_rd_data     (c2_rd_data),
    .c2_rd_valid    (c2_rd_valid),
    .c2_waitrequest (c2_waitrequest),
    .busy           (busy),
    .beat_valid     (beat_valid),
    .beat_client    (beat_client),
    .beat_data      (beat_data),
    .req_rd         (req_rd),
    .req_wr         (req_wr),
    .req_addr       (req_addr),
    .req_burst_len  (req_burst_len),
    .req_wr_data    (req_wr_data),
    .req_wr_be      (req_wr_be),
    .req_client     (req_client)
  );

  burst_seq #(
    .addr_width     (addr_width),
    .burstlen_width (burstlen_width)
  ) seq0 (
    .clock          (clock),
    .rst_n          (rst_n),
    .req_rd         (req_rd),
    .req_wr         (req_wr),
    .req_addr       (req_addr),
    .req_burst_len  (req_burst_len),
    .req_wr_data    (req_wr_data),
    .req_wr_be      (req_wr_be),
    .req_client     (req_client),
    .mem_rd_data    (mem_rd_data),
    .busy           (busy),
    .beat_valid     (beat_valid),
    .beat_client    (beat_client),
    .beat_data      (beat_data),
    .mem_addr       (mem_addr),
    .mem_wr         (mem_wr),
    .mem_wr_data    (mem_wr_data),
    .mem_wr_be      (mem_wr_be)
  );

  mem_array #(
    .addr_width  (addr_width)
  ) ram0 (
    .clock       (clock),
    .mem_addr    (mem_addr),
    .mem_wr      (mem_wr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_be   (mem_wr_be),
    .mem_rd_data (mem_rd_data)
  );

endmodule

`default_nettype wire

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic compare_word(string test, word_t expected, word_t actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", test, expected, actual));
  end
endtask

task automatic compare_client(string test, client_t expected, client_t actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("Mismatch %s: expected %s, actual %s",
                            test, expected.name(), actual.name()));
  end
endtask

task automatic compare_count(string test, int expected, int actual);
  if (actual != expected) begin
    stop_on_error($sformatf("Mismatch %s: expected %0d, actual %0d", test, expected, actual));
  end
endtask

// Model words are taken when the read is accepted
task automatic push_burst(client_t client, addr_t addr, len_t len);
  addr_t a;
  for (int i = 0; i <= int'(len); i++) begin
    a = addr_t'(int'(addr) + i); // Wraps to 0
    if (client == client_instr) begin
      c1_exp_data.push_back(model[a]);
      c1_exp_cycle.push_back(cyc + read_latency + i);
    end else begin
      c2_exp_data.push_back(model[a]);
      c2_exp_cycle.push_back(cyc + read_latency + i);
    end
  end
endtask

task automatic check_beat(client_t client, word_t data);
  if (client == client_instr) begin
    if (c1_exp_data.size() == 0) begin
      stop_on_error("Read data arrived on port c1 with no read outstanding");
    end else begin
      compare_count("burst_timing_c1", c1_exp_cycle.pop_front(), cyc);
      compare_word(phase, c1_exp_data.pop_front(), data);
    end
  end else begin
    if (c2_exp_data.size() == 0) begin
      stop_on_error("Read data arrived on port c2 with no read outstanding");
    end else begin
      compare_count("burst_timing_c2", c2_exp_cycle.pop_front(), cyc);
      compare_word(phase, c2_exp_data.pop_front(), data);
    end
  end
endtask

task automatic check_overdue();
  if (c1_exp_cycle.size() != 0 && c1_exp_cycle[0] <= cyc) begin
    stop_on_error("A read beat on port c1 did not arrive in its cycle");
  end
  if (c2_exp_cycle.size() != 0 && c2_exp_cycle[0] <= cyc) begin
    stop_on_error("A read beat on port c2 did not arrive in its cycle");
  end
endtask

`endif

/* tests/tb_mem_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

  localparam int addr_width     = 10;
  localparam int burstlen_width = 3;
  localparam int depth          = 1 << addr_width;
  localparam int max_beats      = 1 << burstlen_width;
  localparam int seed           = 24881;
  localparam int n_instr        = 300;
  localparam int n_data         = 300;
  localparam int n_requests     = depth + depth / max_beats + n_instr + n_data;

  typedef logic [addr_width-1:0]     addr_t;
  typedef logic [burstlen_width-1:0] len_t;

  logic    clock;
  logic    rst_n;
  addr_t   c1_addr;
  len_t    c1_burst_len;
  logic    c1_rd;
  word_t   c1_rd_data;
  logic    c1_rd_valid;
  logic    c1_waitrequest;
  addr_t   c2_addr;
  len_t    c2_burst_len;
  logic    c2_rd;
  logic    c2_wr;
  word_t   c2_wr_data;
  be_t     c2_wr_be;
  word_t   c2_rd_data;
  logic    c2_rd_valid;
  logic    c2_waitrequest;

  // Reference model and expected beats
  word_t   model [depth];
  word_t   c1_exp_data [$];
  int      c1_exp_cycle [$];
  word_t   c2_exp_data [$];
  int      c2_exp_cycle [$];
  int      cyc = 0;           // Counts falling edges
  int      busy_until = 0;    // Last cycle of the current burst
  client_t last_client = client_data;
  string   phase = "fill";

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  mem_subsys #(
    .addr_width     (addr_width),
    .burstlen_width (burstlen_width)
  ) dut0 (
    .clock          (clock),
    .rst_n          (rst_n),
    .c1_addr        (c1_addr),
    .c1_burst_len   (c1_burst_len),
    .c1_rd          (c1_rd),
    .c1_rd_data     (c1_rd_data),
    .c1_rd_valid    (c1_rd_valid),
    .c1_waitrequest (c1_waitrequest),
    .c2_addr        (c2_addr),
    .c2_burst_len   (c2_burst_len),
    .c2_rd          (c2_rd),
    .c2_wr          (c2_wr),
    .c2_wr_data     (c2_wr_data),
    .c2_wr_be       (c2_wr_be),
    .c2_rd_data     (c2_rd_data),
    .c2_rd_valid    (c2_rd_valid),
    .c2_waitrequest (c2_waitrequest)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // Everything is sampled mid cycle, where inputs and outputs are settled
  task automatic observe_cycle();
    logic    c1_take;
    logic    c2_take;
    client_t winner;
    if ($isunknown({c1_rd_valid, c2_rd_valid, c1_waitrequest, c2_waitrequest})) begin
      stop_on_error("DUT handshake output is unknown after reset");
    end
    if (c2_rd && c2_wr) begin
      stop_on_error("Port c2 raised rd and wr together");
    end
    if ((!c1_rd && !c1_waitrequest) || (!(c2_rd || c2_wr) && !c2_waitrequest)) begin
      stop_on_error("Waitrequest was low on a port with no request");
    end
    c1_take = c1_rd && !c1_waitrequest;
    c2_take = (c2_rd || c2_wr) && !c2_waitrequest;
    if (c1_take && c2_take) begin
      stop_on_error("Both ports were accepted in the same cycle");
    end
    if ((c1_take || c2_take) && cyc <= busy_until) begin
      stop_on_error("A request was accepted while a burst was in progress");
    end
    if (cyc > busy_until && (c1_rd || c2_rd || c2_wr) && !c1_take && !c2_take) begin
      stop_on_error("A pending request was not accepted in an idle cycle");
    end
    if (c1_take || c2_take) begin
      winner = c1_take ? client_instr : client_data;
      if (c1_rd && (c2_rd || c2_wr)) begin // Tie goes to the port not served last
        compare_client("round_robin",
                       (last_client == client_instr) ? client_data : client_instr, winner);
      end
      last_client = winner;
    end
    if (c2_take && c2_wr) begin
      for (int b = 0; b < word_bytes; b++) begin
        if (c2_wr_be[b]) model[c2_addr][8*b +: 8] = c2_wr_data[8*b +: 8];
      end
    end
    if (c1_take) begin
      push_burst(client_instr, c1_addr, c1_burst_len);
      busy_until = cyc + read_latency + int'(c1_burst_len);
    end
    if (c2_take && c2_rd) begin
      push_burst(client_data, c2_addr, c2_burst_len);
      busy_until = cyc + read_latency + int'(c2_burst_len);
    end
    if (c1_rd_valid) check_beat(client_instr, c1_rd_data);
    if (c2_rd_valid) check_beat(client_data, c2_rd_data);
    check_overdue();
  endtask

  always @(negedge clock) begin
    cyc++;
    if (rst_n) observe_cycle();
  end

  // Request stays up until waitrequest is seen low
  task automatic c1_request(addr_t addr, len_t len);
    logic accepted;
    c1_addr      = addr;
    c1_burst_len = len;
    c1_rd        = 1'b1;
    accepted     = 1'b0;
    while (!accepted) begin
      @(negedge clock);
      accepted = !c1_waitrequest;
      @(posedge clock);
      #1;
    end
    c1_rd = 1'b0;
  endtask

  task automatic c2_request(logic rd, logic wr, addr_t addr, len_t len, word_t data, be_t be);
    logic accepted;
    c2_rd        = rd;
    c2_wr        = wr;
    c2_addr      = addr;
    c2_burst_len = len;
    c2_wr_data   = data;
    c2_wr_be     = be;
    accepted     = 1'b0;
    while (!accepted) begin
      @(negedge clock);
      accepted = !c2_waitrequest;
      @(posedge clock);
      #1;
    end
    c2_rd = 1'b0;
    c2_wr = 1'b0;
  endtask

  task automatic idle_gap();
    int n;
    n = $urandom_range(0, 3);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic run_instr_client();
    c1_request(addr_t'(depth - 4), len_t'(max_beats - 1)); // Crosses the top
    for (int i = 1; i < n_instr; i++) begin
      idle_gap();
      c1_request(addr_t'($urandom_range(0, depth - 1)), len_t'($urandom_range(0, max_beats - 1)));
    end
  endtask

  task automatic run_data_client();
    for (int i = 0; i < n_data; i++) begin
      idle_gap();
      if ($urandom_range(0, 1) != 0) begin
        c2_request(1'b1, 1'b0, addr_t'($urandom_range(0, depth - 1)),
                   len_t'($urandom_range(0, max_beats - 1)), '0, '0);
      end else begin
        c2_request(1'b0, 1'b1, addr_t'($urandom_range(0, depth - 1)), '0,
                   word_t'($urandom()), be_t'($urandom_range(1, 14))); // Partial lanes only
      end
    end
  endtask

  task automatic drain_reads();
    while (c1_exp_data.size() != 0 || c2_exp_data.size() != 0) begin
      @(posedge clock);
      #1;
    end
  endtask

  initial begin
    void'($urandom(seed));
    rst_n        = 1'b0;
    c1_addr      = '0;
    c1_burst_len = '0;
    c1_rd        = 1'b0;
    c2_addr      = '0;
    c2_burst_len = '0;
    c2_rd        = 1'b0;
    c2_wr        = 1'b0;
    c2_wr_data   = '0;
    c2_wr_be     = '0;
    repeat (16) @(posedge clock);
    #1;
    rst_n = 1'b1;
    for (int a = 0; a < depth; a++) begin
      c2_request(1'b0, 1'b1, addr_t'(a), '0, word_t'($urandom()), '1);
    end
    phase = "readback";
    for (int a = 0; a < depth; a += max_beats) begin
      c2_request(1'b1, 1'b0, addr_t'(a), len_t'(max_beats - 1), '0, '0);
    end
    drain_reads();
    phase = "mixed";
    fork
      run_instr_client();
      run_data_client();
    join
    drain_reads();
    repeat (4) @(negedge clock); // Catch stray beats
    $display("All tests passed");
    $finish;
  end

  // Every request gets the longest burst plus slack
  initial begin
    repeat (16 + n_requests * (8 + max_beats)) @(posedge clock);
    stop_on_error("Watchdog expired before all requests completed");
  end

endmodule

`default_nettype wire
